// File: dma.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_fifo.sv
logic/dma_regs.sv
logic/dma_sequencer.sv
logic/dma_mover.sv
logic/dma_top.sv
verif/dma_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dma copy engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
   --top-module dma_tb \
   -f dma.f \
   -o dma_sim

./obj_dir/dma_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
   exit 1
fi

exit 0

// File: verif/dma_tb.sv
/*
 * dma copy engine testbench
 * table of transfers, memory model with random latency and back-pressure,
 * per-word read and write checks, irq checks, timeout
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_tb;
   import dma_pkg::*;

   localparam logic [31:0] SEED        = 32'h30f0_7d47;
   localparam data_t       MEM_KEY     = 32'h5a5a_0000; // memory data = addr ^ key
   localparam data_t       CFG_DMA_EN  = 32'h0000_0001; // config bit 0
   localparam data_t       CFG_IRQMODE = 32'h0000_0010; // config bit 4
   localparam int          NUM_ROWS    = 6;
   localparam int          IRQ_WAIT    = 16; // max cycles from last write to irq
   localparam int          SETTLE      = 10; // quiet window after each transfer

   typedef struct packed {
      addr_t src;
      addr_t dst;
      data_t count;
      addr_t stride;
      logic  irqmode;
   } row_t;

   logic                  clk;
   logic                  nreset;
   logic                  reg_valid;
   mesh_packet_t          reg_packet;
   logic                  rd_valid;
   rd_req_t               rd_req;
   logic                  rd_ready;
   logic                  rsp_valid;
   data_t                 rsp_data;
   logic                  rsp_ready;
   logic                  wr_valid;
   mesh_packet_t          wr_packet;
   logic                  wr_ready;
   logic                  irq;

   row_t        rows [NUM_ROWS];
   row_t        cur;            // row under test
   int          row_num;
   int          rd_idx;         // reads seen in this row
   int          wr_idx;         // writes seen in this row
   int          value_errors;
   int          other_errors;
   int          cycles;
   int          limit;
   int          mem_time;
   int          waited;
   int          r;
   logic        exp_irq;
   logic        irq_flagged;    // report irq trouble once per phase
   // handshakes seen at negedge complete at the next rising edge
   logic        rd_fire;
   logic        wr_fire;
   logic        rsp_fire;
   addr_t       rd_addr_seen;
   addr_t       rsp_addr_q [$]; // outstanding reads in order
   int          rsp_time_q [$]; // earliest return time of each

   dma_top DUT (
      .clk        (clk),
      .nreset     (nreset),
      .reg_valid  (reg_valid),
      .reg_packet (reg_packet),
      .rd_valid   (rd_valid),
      .rd_req     (rd_req),
      .rd_ready   (rd_ready),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .rsp_ready  (rsp_ready),
      .wr_valid   (wr_valid),
      .wr_packet  (wr_packet),
      .wr_ready   (wr_ready),
      .irq        (irq)
   );

   always #2 clk = ~clk; // 4 ns period

   function automatic row_t make_row(input addr_t src, input addr_t dst, input data_t count,
                                     input addr_t stride, input logic irqmode);
      row_t row;
      row.src     = src;
      row.dst     = dst;
      row.count   = count;
      row.stride  = stride;
      row.irqmode = irqmode;
      return row;
   endfunction

   task automatic load_table;
      rows[0] = make_row(32'h0000_1000, 32'h0000_8000, 32'd3,  32'h4,  1'b1);
      rows[1] = make_row(32'h0001_0000, 32'h0002_0000, 32'd12, 32'h4,  1'b0); // > depth
      rows[2] = make_row(32'h0000_3000, 32'h0000_3100, 32'd0,  32'h4,  1'b1); // empty
      rows[3] = make_row(32'h00ab_0040, 32'h00cd_0080, 32'd9,  32'h10, 1'b1);
      rows[4] = make_row(32'hffff_fff0, 32'h0000_0200, 32'd6,  32'h8,  1'b1); // src wraps
      rows[5] = make_row(32'h0004_0000, 32'h0005_0000, 32'd1,  32'h4,  1'b0);
   endtask

   // single register write packet held for one cycle
   task automatic write_register(input logic [4:0] idx, input data_t data);
      mesh_packet_t pkt;
      pkt.write   = 1'b1;
      pkt.dstaddr = {25'd0, idx, 2'b00}; // word index in addr[6:2]
      pkt.srcaddr = '0;
      pkt.data    = data;
      @(posedge clk);
      reg_valid  <= 1'b1;
      reg_packet <= pkt;
      @(posedge clk);
      reg_valid  <= 1'b0;
   endtask

   // one-bit output against its expected level
   task automatic compare_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("** Error: %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_read(input addr_t addr);
      addr_t exp_addr;
      exp_addr = cur.src + 32'(rd_idx) * cur.stride;
      if (rd_idx >= cur.count) begin
         other_errors++;
         $display("unexpected read request at %h in row %0d", addr, row_num);
      end else if (addr !== exp_addr) begin
         value_errors++;
         $display("** Error: rd_req.addr row %0d word %0d: got %h expected %h",
                  row_num, rd_idx, addr, exp_addr);
      end
      rd_idx++;
   endtask

   task automatic check_write(input mesh_packet_t pkt);
      addr_t exp_dst;
      addr_t exp_src;
      data_t exp_data;
      exp_dst  = cur.dst + 32'(wr_idx) * cur.stride;
      exp_src  = cur.src + 32'(wr_idx) * cur.stride;
      exp_data = exp_src ^ MEM_KEY;
      if (wr_idx >= cur.count) begin
         other_errors++;
         $display("unexpected write to %h in row %0d after all %0d words",
                  pkt.dstaddr, row_num, cur.count);
      end else begin
         if (pkt.write !== 1'b1) begin
            value_errors++;
            $display("** Error: wr_packet.write row %0d word %0d: got %h expected 1",
                     row_num, wr_idx, pkt.write);
         end
         if (pkt.dstaddr !== exp_dst) begin
            value_errors++;
            $display("** Error: wr_packet.dstaddr row %0d word %0d: got %h expected %h",
                     row_num, wr_idx, pkt.dstaddr, exp_dst);
         end
         if (pkt.srcaddr !== exp_src) begin
            value_errors++;
            $display("** Error: wr_packet.srcaddr row %0d word %0d: got %h expected %h",
                     row_num, wr_idx, pkt.srcaddr, exp_src);
         end
         if (pkt.data !== exp_data) begin
            value_errors++;
            $display("** Error: wr_packet.data row %0d word %0d: got %h expected %h",
                     row_num, wr_idx, pkt.data, exp_data);
         end
      end
      wr_idx++;
   endtask

   task automatic finish_run;
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   endtask

   //########################################
   // monitor samples stable outputs at negedge
   //########################################
   always @(negedge clk) begin
      rd_fire  = nreset & rd_valid & rd_ready;
      wr_fire  = nreset & wr_valid & wr_ready;
      rsp_fire = nreset & rsp_valid & rsp_ready;
      if (rd_fire) begin
         rd_addr_seen = rd_req.addr;
         check_read(rd_req.addr);
      end
      if (wr_fire)
         check_write(wr_packet);
   end

   //########################################
   // memory model and back-pressure
   //########################################
   always @(posedge clk) begin
      mem_time++;
      if (nreset) begin
         if (rsp_fire) begin
            void'(rsp_addr_q.pop_front()); // word taken this edge
            void'(rsp_time_q.pop_front());
         end
         if (rd_fire) begin
            rsp_addr_q.push_back(rd_addr_seen);
            rsp_time_q.push_back(mem_time + int'($urandom % 4)); // 0..3 cycles
         end
         if (rsp_addr_q.size() != 0 && mem_time >= rsp_time_q[0]) begin
            rsp_valid <= 1'b1;
            rsp_data  <= rsp_addr_q[0] ^ MEM_KEY;
         end else begin
            rsp_valid <= 1'b0;
         end
         rd_ready <= ($urandom % 4) != 0; // ready 3 of 4
         wr_ready <= ($urandom % 3) != 0; // ready 2 of 3
      end
   end

   // watchdog
   initial begin
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      other_errors++;
      $display("timeout after %0d cycles in row %0d: %0d of %0d writes seen",
               cycles, row_num, wr_idx, cur.count);
      finish_run();
   end

   //########################################
   // main sequence
   //########################################
   initial begin
      clk          = 1'b0;
      nreset       = 1'b0;
      reg_valid    = 1'b0;
      reg_packet   = '0;
      rd_ready     = 1'b0;
      wr_ready     = 1'b0;
      rsp_valid    = 1'b0;
      rsp_data     = '0;
      rd_fire      = 1'b0;
      wr_fire      = 1'b0;
      rsp_fire     = 1'b0;
      cur          = '0; // no transfer yet so any access is unexpected
      value_errors = 0;
      other_errors = 0;
      cycles       = 0;
      mem_time     = 0;
      void'($urandom(SEED));
      load_table();
      limit = 200;
      for (r = 0; r < NUM_ROWS; r++)
         limit = limit + 40 * int'(rows[r].count);

      repeat (8) @(posedge clk);
      nreset <= 1'b1;

      // quiet outputs after reset
      @(negedge clk);
      compare_level("rd_valid after reset", rd_valid, 1'b0);
      compare_level("wr_valid after reset", wr_valid, 1'b0);
      compare_level("irq after reset", irq, 1'b0);
      compare_level("rsp_ready after reset", rsp_ready, 1'b1);

      for (r = 0; r < NUM_ROWS; r++) begin
         cur     = rows[r];
         row_num = r;
         rd_idx  = 0;
         wr_idx  = 0;
         exp_irq = cur.irqmode & (cur.count != '0); // empty row never finishes
         write_register(`DMA_REG_STRIDE,  cur.stride);
         write_register(`DMA_REG_COUNT,   cur.count);
         write_register(`DMA_REG_SRCADDR, cur.src);
         write_register(`DMA_REG_DSTADDR, cur.dst);
         write_register(`DMA_REG_CONFIG,  CFG_DMA_EN | (cur.irqmode ? CFG_IRQMODE : '0));

         // wait for all writes with irq low
         irq_flagged = 1'b0;
         while (wr_idx < cur.count) begin
            @(negedge clk);
            if (irq && !irq_flagged) begin
               irq_flagged = 1'b1;
               other_errors++;
               $display("irq rose before the last write of row %0d", r);
            end
         end

         if (exp_irq) begin
            waited = 0;
            while (!irq && waited < IRQ_WAIT) begin
               @(negedge clk);
               waited++;
            end
            if (!irq) begin
               other_errors++;
               $display("irq did not rise after the last write of row %0d", r);
            end
         end

         // no stray traffic while irq holds its level
         irq_flagged = 1'b0;
         repeat (SETTLE) begin
            @(negedge clk);
            if (irq !== exp_irq && !irq_flagged) begin
               irq_flagged = 1'b1;
               value_errors++;
               $display("** Error: irq row %0d: got %h expected %h", r, irq, exp_irq);
            end
         end
         if (rd_idx != int'(cur.count)) begin
            other_errors++;
            $display("row %0d issued %0d reads instead of %0d", r, rd_idx, cur.count);
         end

         write_register(`DMA_REG_STATUS, '0); // ack irq
         @(negedge clk);
         if (irq !== 1'b0) begin
            value_errors++;
            $display("** Error: irq after status write row %0d: got %h expected 0", r, irq);
         end
      end

      finish_run();
   end

endmodule

`default_nettype wire

// File: logic/dma_top.sv
/*
 * dma copy engine top
 * register block, sequencer, command buffer and mover
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_top (
   input  wire                   clk,
   input  wire                   nreset,
   // register writes
   input  wire                   reg_valid,
   input  dma_pkg::mesh_packet_t reg_packet,
   // memory read port
   output logic                  rd_valid,
   output dma_pkg::rd_req_t      rd_req,
   input  wire                   rd_ready,
   input  wire                   rsp_valid,
   input  dma_pkg::data_t        rsp_data,
   output logic                  rsp_ready,
   // write output
   output logic                  wr_valid,
   output dma_pkg::mesh_packet_t wr_packet,
   input  wire                   wr_ready,
   output logic                  irq
);
   import dma_pkg::*;

   // regs <-> sequencer
   dma_cfg_t   cfg;
   logic       start;
   addr_t      stride;
   data_t      count_reg;
   addr_t      srcaddr_reg;
   addr_t      dstaddr_reg;
   logic       update;
   data_t      count;
   addr_t      srcaddr;
   addr_t      dstaddr;
   seq_state_t state;
   logic       done;
   // command path
   logic       seq_cmd_valid;
   logic       seq_cmd_ready;
   copy_cmd_t  seq_cmd;
   logic       mv_cmd_valid;
   logic       mv_cmd_ready;
   copy_cmd_t  mv_cmd;
   logic       wr_done;

   dma_regs u_regs (
      .clk         (clk),
      .nreset      (nreset),
      .reg_valid   (reg_valid),
      .reg_packet  (reg_packet),
      .update      (update),
      .count       (count),
      .srcaddr     (srcaddr),
      .dstaddr     (dstaddr),
      .state       (state),
      .done        (done),
      .cfg         (cfg),
      .start       (start),
      .stride      (stride),
      .count_reg   (count_reg),
      .srcaddr_reg (srcaddr_reg),
      .dstaddr_reg (dstaddr_reg),
      .irq         (irq)
   );

   dma_sequencer u_seq (
      .clk         (clk),
      .nreset      (nreset),
      .cfg         (cfg),
      .start       (start),
      .stride      (stride),
      .count_reg   (count_reg),
      .srcaddr_reg (srcaddr_reg),
      .dstaddr_reg (dstaddr_reg),
      .cmd_ready   (seq_cmd_ready),
      .wr_done     (wr_done),
      .cmd_valid   (seq_cmd_valid),
      .cmd         (seq_cmd),
      .update      (update),
      .count       (count),
      .srcaddr     (srcaddr),
      .dstaddr     (dstaddr),
      .state       (state),
      .done        (done)
   );

   dma_fifo #(
      .item_t (copy_cmd_t),
      .DEPTH  (`DMA_CMD_DEPTH)
   ) cmd_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .in_valid  (seq_cmd_valid),
      .in_item   (seq_cmd),
      .in_ready  (seq_cmd_ready),
      .out_ready (mv_cmd_ready),
      .out_valid (mv_cmd_valid),
      .out_item  (mv_cmd)
   );

   dma_mover u_mover (
      .clk       (clk),
      .nreset    (nreset),
      .cmd_valid (mv_cmd_valid),
      .cmd       (mv_cmd),
      .cmd_ready (mv_cmd_ready),
      .rd_ready  (rd_ready),
      .rd_valid  (rd_valid),
      .rd_req    (rd_req),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_ready (rsp_ready),
      .wr_ready  (wr_ready),
      .wr_valid  (wr_valid),
      .wr_packet (wr_packet),
      .wr_done   (wr_done)
   );

endmodule

`default_nettype wire

// File: logic/dma_mover.sv
/*
 * dma mover
 * reads the source word of the head command, buffers the return and
 * emits the write packet to the command's destination
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_mover (
   input  wire                   clk,
   input  wire                   nreset,
   // command buffer pop side
   input  wire                   cmd_valid,
   input  dma_pkg::copy_cmd_t    cmd,
   output logic                  cmd_ready,
   // memory read port
   input  wire                   rd_ready,
   output logic                  rd_valid,
   output dma_pkg::rd_req_t      rd_req,
   input  wire                   rsp_valid,
   input  dma_pkg::data_t        rsp_data,
   output logic                  rsp_ready,
   // write output
   input  wire                   wr_ready,
   output logic                  wr_valid,
   output dma_pkg::mesh_packet_t wr_packet,
   output logic                  wr_done
);
   import dma_pkg::*;

   logic  rd_sent;   // read issued for head command
   logic  buf_valid;
   data_t buf_data;
   logic  wr_fire;

   // returned words, in request order
   dma_fifo #(
      .item_t (data_t),
      .DEPTH  (`DMA_RSP_DEPTH)
   ) rsp_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .in_valid  (rsp_valid),
      .in_item   (rsp_data),
      .in_ready  (rsp_ready),
      .out_ready (wr_fire),   // word leaves with its write
      .out_valid (buf_valid),
      .out_item  (buf_data)
   );

   // one read in flight
   assign rd_valid    = cmd_valid & ~rd_sent;
   assign rd_req.addr = cmd.srcaddr;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rd_sent <= 1'b0;
      else if (wr_fire)
         rd_sent <= 1'b0;
      else if (rd_valid & rd_ready)
         rd_sent <= 1'b1;
   end

   //########################################
   // write stage
   //########################################
   assign wr_valid          = cmd_valid & rd_sent & buf_valid;
   assign wr_packet.write   = 1'b1;
   assign wr_packet.dstaddr = cmd.dstaddr;
   assign wr_packet.srcaddr = cmd.srcaddr; // origin of the word
   assign wr_packet.data    = buf_data;
   assign wr_fire           = wr_valid & wr_ready;
   assign cmd_ready         = wr_fire; // pop command on accepted write
   assign wr_done           = wr_fire;

endmodule

`default_nettype wire

// File: logic/dma_sequencer.sv
/*
 * dma sequencer
 * walks the transfer one word per cycle, pushes copy commands and
 * writes the advanced count and addresses back to the registers
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_sequencer (
   input  wire                   clk,
   input  wire                   nreset,
   input  dma_pkg::dma_cfg_t     cfg,
   input  wire                   start,
   input  dma_pkg::addr_t        stride,
   input  dma_pkg::data_t        count_reg,
   input  dma_pkg::addr_t        srcaddr_reg,
   input  dma_pkg::addr_t        dstaddr_reg,
   // command buffer push side
   input  wire                   cmd_ready,
   input  wire                   wr_done,
   output logic                  cmd_valid,
   output dma_pkg::copy_cmd_t    cmd,
   // register write back
   output logic                  update,
   output dma_pkg::data_t        count,
   output dma_pkg::addr_t        srcaddr,
   output dma_pkg::addr_t        dstaddr,
   output dma_pkg::seq_state_t   state,
   output logic                  done
);
   import dma_pkg::*;

   // enough for a full command buffer, one read and the write stage
   localparam int PEND_W = $clog2(`DMA_CMD_DEPTH) + 3;

   logic              push;
   logic              go;
   logic              finished;
   logic [PEND_W-1:0] pending; // pushed but not yet written

   //########################################
   // command generation
   //########################################
   assign cmd_valid   = (state == SEQ_BUSY) & (count_reg != '0);
   assign cmd.srcaddr = srcaddr_reg;
   assign cmd.dstaddr = dstaddr_reg;
   assign push        = cmd_valid & cmd_ready;

   // advanced values, loaded by dma_regs on update
   assign update  = push;
   assign count   = count_reg - 1'b1;
   assign srcaddr = srcaddr_reg + stride;
   assign dstaddr = dstaddr_reg + stride;

   //########################################
   // outstanding writes
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         pending <= '0;
      else
         case ({push, wr_done})
            2'b10:   pending <= pending + 1'b1;
            2'b01:   pending <= pending - 1'b1;
            default: pending <= pending; // both or none
         endcase
   end

   //########################################
   // state machine
   //########################################
   assign go       = start & cfg.dma_en & (count_reg != '0);
   assign finished = (state == SEQ_BUSY) & (count_reg == '0) & (pending == '0);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state <= SEQ_IDLE;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start & ~cfg.dma_en) begin
            state <= SEQ_IDLE; // disabled by software
         end else begin
            case (state)
               SEQ_IDLE: if (go) state <= SEQ_BUSY;
               SEQ_BUSY: begin
                  if (finished) begin
                     state <= SEQ_DONE;
                     done  <= 1'b1; // single pulse on entry
                  end
               end
               SEQ_DONE: if (go) state <= SEQ_BUSY; // restart without idle
               default:  state <= SEQ_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/dma_regs.sv
/*
 * dma configuration registers
 * decodes mesh write packets, holds transfer registers, mirrors the live
 * count and addresses from the sequencer and keeps the irq pending flag
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_regs (
   input  wire                      clk,
   input  wire                      nreset,
   // register write port, always accepted
   input  wire                      reg_valid,
   input  dma_pkg::mesh_packet_t    reg_packet,
   // live values from sequencer
   input  wire                      update,
   input  dma_pkg::data_t           count,
   input  dma_pkg::addr_t           srcaddr,
   input  dma_pkg::addr_t           dstaddr,
   input  dma_pkg::seq_state_t      state,
   input  wire                      done,
   // to sequencer
   output dma_pkg::dma_cfg_t        cfg,
   output logic                     start,
   output dma_pkg::addr_t           stride,
   output dma_pkg::data_t           count_reg,
   output dma_pkg::addr_t           srcaddr_reg,
   output dma_pkg::addr_t           dstaddr_reg,
   output logic                     irq
);
   import dma_pkg::*;

   logic       reg_write;
   logic [4:0] reg_idx;
   logic       config_write;
   logic       stride_write;
   logic       count_write;
   logic       srcaddr_write;
   logic       dstaddr_write;
   logic       status_write;
   logic       irq_set;
   data_t      status_reg;

   //########################################
   // decode
   //########################################
   assign reg_write     = reg_valid & reg_packet.write;
   assign reg_idx       = reg_packet.dstaddr[6:2]; // word index
   assign config_write  = reg_write & (reg_idx == `DMA_REG_CONFIG);
   assign stride_write  = reg_write & (reg_idx == `DMA_REG_STRIDE);
   assign count_write   = reg_write & (reg_idx == `DMA_REG_COUNT);
   assign srcaddr_write = reg_write & (reg_idx == `DMA_REG_SRCADDR);
   assign dstaddr_write = reg_write & (reg_idx == `DMA_REG_DSTADDR);
   assign status_write  = reg_write & (reg_idx == `DMA_REG_STATUS);

   //########################################
   // config and start
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg   <= '0;
         start <= 1'b0;
      end else begin
         start <= config_write; // one cycle after, cfg already loaded
         if (config_write)
            cfg <= dma_cfg_t'(reg_packet.data);
      end
   end

   //########################################
   // datapath registers
   //########################################
   always_ff @(posedge clk) begin
      if (stride_write)
         stride <= addr_t'(reg_packet.data);
   end

   // software write wins over sequencer mirror
   always_ff @(posedge clk) begin
      if (count_write)
         count_reg <= reg_packet.data;
      else if (update)
         count_reg <= count;
   end

   always_ff @(posedge clk) begin
      if (srcaddr_write)
         srcaddr_reg <= addr_t'(reg_packet.data);
      else if (update)
         srcaddr_reg <= srcaddr;
   end

   always_ff @(posedge clk) begin
      if (dstaddr_write)
         dstaddr_reg <= addr_t'(reg_packet.data);
      else if (update)
         dstaddr_reg <= dstaddr;
   end

   //########################################
   // status and irq
   //########################################
   assign irq_set = done & cfg.irqmode;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         status_reg <= '0;
      end else if (status_write) begin
         status_reg <= reg_packet.data;
         status_reg[`DMA_STATUS_IRQ] <= 1'b0; // any status write acks irq
      end else begin
         if (config_write) begin
            status_reg[31:16] <= cfg.next_descr; // current descriptor
            status_reg[1:0]   <= state;          // state at (re)start
         end
         if (irq_set)
            status_reg[`DMA_STATUS_IRQ] <= 1'b1;
      end
   end

   assign irq = status_reg[`DMA_STATUS_IRQ];

endmodule

`default_nettype wire

// File: logic/dma_fifo.sv
/*
 * synchronous valid/ready buffer
 * circular storage with occupancy count, payload type set per instance
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_fifo #(
   parameter type item_t = logic,
   parameter int  DEPTH  = `DMA_CMD_DEPTH
) (
   input  wire   clk,
   input  wire   nreset,
   // push side
   input  wire   in_valid,
   input  item_t in_item,
   output logic  in_ready,
   // pop side
   input  wire   out_ready,
   output logic  out_valid,
   output item_t out_item
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int OCC_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
   localparam logic [OCC_W-1:0] FULL = OCC_W'(DEPTH);

   item_t             mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [OCC_W-1:0]  occ;
   logic              push;
   logic              pop;

   assign out_valid = (occ != '0);
   assign out_item  = mem[rd_ptr];
   assign in_ready  = (occ != FULL) | out_ready; // full but draining is ok
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // storage
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_item;
   end

   //########################################
   // pointers and occupancy
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/dma_pkg.sv
/*
 * dma shared types
 * mesh packet, read request, copy command, config fields, sequencer state
 */
`default_nettype none
`include "dma_settings.svh"

package dma_pkg;

   typedef logic [`DMA_AW-1:0] addr_t;
   typedef logic [`DMA_DW-1:0] data_t;

   // mesh packet for the register port and write output
   typedef struct packed {
      logic  write;   // 1 = write transaction
      addr_t dstaddr; // target address
      addr_t srcaddr; // return address
      data_t data;    // payload word
   } mesh_packet_t;

   typedef struct packed {
      addr_t addr; // word to fetch
   } rd_req_t;

   // one word copy
   typedef struct packed {
      addr_t srcaddr;
      addr_t dstaddr;
   } copy_cmd_t;

   // config register layout from bit 31 down
   typedef struct packed {
      logic [15:0] next_descr; // next descriptor pointer for status
      logic [10:0] rsvd_hi;    // unused
      logic        irqmode;    // irq at end of transfer
      logic [2:0]  rsvd_mode;  // unused chain/master/manual bits
      logic        dma_en;     // enable
   } dma_cfg_t;

   typedef enum logic [1:0] {
      SEQ_IDLE = 2'd0,
      SEQ_BUSY = 2'd1,
      SEQ_DONE = 2'd2
   } seq_state_t;

endpackage

`default_nettype wire

// File: logic/dma_settings.svh
/*
 * dma copy engine settings
 * bus widths, buffer depths and register word map
 */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// bus widths
`define DMA_AW 32 // address width
`define DMA_DW 32 // data width

// buffer depths
`define DMA_CMD_DEPTH 4 // copy commands between sequencer and mover
`define DMA_RSP_DEPTH 4 // returned read words

//########################################
// register word offsets in addr[6:2]
//########################################
`define DMA_REG_CONFIG  5'd0
`define DMA_REG_STRIDE  5'd1
`define DMA_REG_COUNT   5'd2
`define DMA_REG_SRCADDR 5'd3 // 5'd4 unused high source word
`define DMA_REG_DSTADDR 5'd5 // 5'd6 unused high dest word
`define DMA_REG_STATUS  5'd7

// status register fields
`define DMA_STATUS_IRQ 8 // irq pending bit

`endif
